// ==== Bender.yml ====
package:
  name: sys1_cart

sources:
  # RTL in compile order
  - files:
      - hdl/sys1_cart_pkg.sv
      - hdl/rom_load_decode.sv
      - hdl/rom_bank.sv
      - hdl/cart_read_select.sv
      - hdl/control_map.sv
      - hdl/sys1_cart_top.sv
  # Testbench
  - target: test
    files:
      - verif/tb_sys1_cart.sv

// ==== hdl/cart_read_select.sv ====
// Cartridge read multiplexer, picks the lowest selected bank behind active-low chip selects
`timescale 1ns/1ps

module cart_read_select
	import sys1_cart_pkg::*;
#(
	parameter type payload_t = word_t,
	parameter int n_banks = main_banks
) (
	input logic clk_sys,
	input logic arst_n,
	// Chip selects, active low, bit 0 has priority
	input logic [n_banks-1:0] sel_n,
	// Registered bank outputs
	input payload_t bank_data [n_banks],
	output payload_t rd_data
);

	logic [n_banks-1:0] sel_n_q;

	// ####################
	// Select alignment
	// ####################

	// Delayed one cycle to meet the registered bank data
	// All inactive out of reset
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sel_n_q <= '1;
		end else begin
			sel_n_q <= sel_n;
		end
	end

	// ####################
	// Priority pick
	// ####################

	// Scan from the top so the lowest selected bank wins
	// Zero when nothing is selected
	always_comb begin
		rd_data = '0;
		for (int i = n_banks - 1; i >= 0; i--) begin
			if (!sel_n_q[i])
				rd_data = bank_data[i];
		end
	end

endmodule

// ==== hdl/control_map.sv ====
// Player control mapper that latches keyboard events and lays out joystick and pushbutton buses
`timescale 1ns/1ps

module control_map
	import sys1_cart_pkg::*;
(
	input logic clk_sys,
	input logic arst_n,
	// Bit 10 toggle, bit 9 pressed, bits 8..0 scan code
	input logic [10:0] ps2_key,
	// Host joystick buttons
	input logic [31:0] joystick,
	input byte_t game_id,
	// Board inputs
	output byte_t joy,
	output byte_t pb,
	output logic [2:0] coin_n
);

	logic toggle_q;
	logic pressed;
	// Up, down, left, right
	logic [3:0] dir_q;
	logic whip_q;
	logic jump_q;
	logic coin_l_q;
	logic coin_r_q;
	logic coin_aux_q;
	logic [3:0] dir;
	logic whip;
	logic jump;

	assign pressed = ps2_key[9];

	// ####################
	// Key latches
	// ####################

	// A new key event flips bit 10
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q <= 1'b0;
			dir_q <= '0;
			whip_q <= 1'b0;
			jump_q <= 1'b0;
			coin_l_q <= 1'b0;
			coin_r_q <= 1'b0;
			coin_aux_q <= 1'b0;
		end else begin
			toggle_q <= ps2_key[10];
			if (toggle_q != ps2_key[10]) begin
				case (ps2_key[8:0])
					key_up: dir_q[3] <= pressed;
					key_down: dir_q[2] <= pressed;
					key_left: dir_q[1] <= pressed;
					key_right: dir_q[0] <= pressed;
					key_whip: whip_q <= pressed;
					key_jump: jump_q <= pressed;
					key_coin_l: coin_l_q <= pressed;
					key_coin_r: coin_r_q <= pressed;
					key_coin_aux: coin_aux_q <= pressed;
					// Other keys leave the latches alone
					default: ;
				endcase
			end
		end
	end

	// Keyboard or host joystick
	assign dir = dir_q | joystick[3:0];
	assign jump = jump_q | joystick[4];
	assign whip = whip_q | joystick[5];

	// ####################
	// Per-game layout
	// ####################

	// Indy wants the directions one bit up
	assign joy = (game_id == game_indy) ? {3'b000, dir, 1'b0} : {4'b0000, dir};

	// Active low pushbuttons with idle bits high
	// Peter has a gap between jump and throw
	assign pb = (game_id == game_peter) ? {5'b11111, ~jump, 1'b1, ~whip}
		: {6'b111111, ~jump, ~whip};

	// Aux, right, left
	assign coin_n = {~coin_aux_q, ~coin_r_q, ~(coin_l_q | joystick[8])};

endmodule

// ==== hdl/rom_bank.sv ====
// Dual-port ROM bank, written from the download stream and read synchronously by a CPU
`timescale 1ns/1ps

module rom_bank
	import sys1_cart_pkg::*;
#(
	parameter int addr_bits = rom_bits_short,
	parameter type payload_t = word_t
) (
	input logic clk_sys,
	// Load port
	input logic wr,
	input load_addr_t load_addr,
	input payload_t wr_data,
	// CPU read port
	input main_addr_t rd_addr,
	output payload_t rd_data
);

	// Word banks drop the byte lane bit of the stream address
	localparam int word_shift = ($bits(payload_t) > $bits(byte_t)) ? 1 : 0;
	localparam int depth = 2 ** addr_bits;

	payload_t mem [depth];
	logic [addr_bits-1:0] wr_idx;
	logic [addr_bits-1:0] rd_idx;

	// Stream byte address to bank entry
	assign wr_idx = load_addr[word_shift +: addr_bits];
	// Narrow sound addresses arrive zero extended
	assign rd_idx = rd_addr[addr_bits-1:0];

	// Load port
	always_ff @(posedge clk_sys) begin
		if (wr)
			mem[wr_idx] <= wr_data;
	end

	// Registered read, data one cycle after address
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_idx];
	end

endmodule

// ==== hdl/rom_load_decode.sv ====
// ROM download decoder, pairs stream bytes into words and strobes the target bank
`timescale 1ns/1ps

module rom_load_decode
	import sys1_cart_pkg::*;
(
	input logic clk_sys,
	input logic arst_n,
	// Download stream
	input logic ioctl_download,
	input logic ioctl_wr,
	input byte_t ioctl_index,
	input load_addr_t ioctl_addr,
	input byte_t ioctl_dout,
	// Bank load side
	output load_addr_t load_addr,
	output word_t load_word,
	output byte_t load_byte,
	output logic wr_rom0,
	output logic wr_rom1,
	output logic wr_rom2,
	output logic wr_rom3,
	output logic wr_slap,
	output logic wr_srom0,
	output logic wr_srom1,
	output logic wr_srom2,
	// Selected game
	output byte_t game_id
);

	logic rom_byte;
	logic rom_odd;
	byte_t prev_byte;

	// A ROM byte needs the strobe, index 0 and an active download
	assign rom_byte = ioctl_wr && ioctl_download && (ioctl_index == rom_index);
	// Word regions complete on the odd byte
	assign rom_odd = rom_byte && ioctl_addr[0];

	// ####################
	// Byte accumulator
	// ####################

	// Holds the even byte until its odd partner arrives
	always_ff @(posedge clk_sys) begin
		if (rom_byte)
			prev_byte <= ioctl_dout;
	end

	// Even byte is the high half
	assign load_word = {prev_byte, ioctl_dout};
	assign load_byte = ioctl_dout;
	assign load_addr = ioctl_addr;

	// ####################
	// Region strobes
	// ####################

	// Main program words, 32K or 64K byte regions
	assign wr_rom0 = rom_odd && (ioctl_addr[24:15] == tag_rom0);
	assign wr_rom1 = rom_odd && (ioctl_addr[24:16] == tag_rom1);
	assign wr_rom2 = rom_odd && (ioctl_addr[24:16] == tag_rom2);
	assign wr_rom3 = rom_odd && (ioctl_addr[24:15] == tag_rom3);
	// Bank-switched slapstic region
	assign wr_slap = rom_odd && (ioctl_addr[24:15] == tag_slap);

	// Sound bytes, every byte strobes
	assign wr_srom0 = rom_byte && (ioctl_addr[24:14] == tag_srom0);
	assign wr_srom1 = rom_byte && (ioctl_addr[24:14] == tag_srom1);
	assign wr_srom2 = rom_byte && (ioctl_addr[24:14] == tag_srom2);

	// ####################
	// Game identifier
	// ####################

	// Index 1 carries the game byte
	// Loaded with or without the download level
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game_id <= game_default;
		end else if (ioctl_wr && (ioctl_index == id_index)) begin
			game_id <= ioctl_dout;
		end
	end

endmodule

// ==== hdl/sys1_cart_pkg.sv ====
// System-1 cartridge shared widths, types, region tags, scan codes and game identifiers
package sys1_cart_pkg;

	// ####################
	// Widths and types
	// ####################

	// Download stream byte address
	localparam int load_addr_bits = 25;
	// Main CPU word address and sound CPU byte address
	localparam int main_addr_bits = 15;
	localparam int sound_addr_bits = 14;

	typedef logic [load_addr_bits-1:0] load_addr_t;
	typedef logic [15:0] word_t;
	typedef logic [7:0] byte_t;

	// Chip selects, active low
	typedef logic [3:0] main_sel_t;
	typedef logic [2:0] sound_sel_t;

	typedef logic [main_addr_bits-1:0] main_addr_t;
	typedef logic [sound_addr_bits-1:0] sound_addr_t;

	// Bank counts on each CPU side
	// Main side is rom0..rom3 plus the slapstic bank
	localparam int main_banks = 5;
	localparam int sound_banks = 3;

	// Bank depths in address bits
	localparam int rom_bits_short = 14;
	localparam int rom_bits_long = 15;

	// ####################
	// Download regions
	// ####################

	// Matched against ioctl_addr[24:15]
	localparam logic [9:0] tag_rom0 = 10'h16;
	localparam logic [9:0] tag_rom3 = 10'h14;
	localparam logic [9:0] tag_slap = 10'h15;
	// Matched against ioctl_addr[24:16]
	localparam logic [8:0] tag_rom1 = 9'h08;
	localparam logic [8:0] tag_rom2 = 9'h09;
	// Matched against ioctl_addr[24:14]
	localparam logic [10:0] tag_srom0 = 11'h2E;
	localparam logic [10:0] tag_srom1 = 11'h2F;
	localparam logic [10:0] tag_srom2 = 11'h30;

	// Stream index values
	localparam byte_t rom_index = 8'd0;
	localparam byte_t id_index = 8'd1;

	// ####################
	// Keys and games
	// ####################

	// PS/2 scan codes, extended flag in bit 8
	localparam logic [8:0] key_up = 9'h175;
	localparam logic [8:0] key_down = 9'h172;
	localparam logic [8:0] key_left = 9'h16B;
	localparam logic [8:0] key_right = 9'h174;
	localparam logic [8:0] key_whip = 9'h014;
	localparam logic [8:0] key_jump = 9'h011;
	localparam logic [8:0] key_coin_l = 9'h02E;
	localparam logic [8:0] key_coin_r = 9'h036;
	localparam logic [8:0] key_coin_aux = 9'h03D;

	// Slapstic game identifiers
	localparam byte_t game_marble = 8'd103;
	localparam byte_t game_indy = 8'd105;
	localparam byte_t game_peter = 8'd107;
	localparam byte_t game_default = game_indy;

endpackage

// ==== hdl/sys1_cart_top.sv ====
// System-1 cartridge top, ROM download, bank reads and player control mapping
`timescale 1ns/1ps

module sys1_cart_top
	import sys1_cart_pkg::*;
(
	input logic clk_sys,
	input logic arst_n,
	// Download stream
	input logic ioctl_download,
	input logic ioctl_wr,
	input byte_t ioctl_index,
	input load_addr_t ioctl_addr,
	input byte_t ioctl_dout,
	// Main CPU side
	input main_addr_t madec,
	input main_sel_t rom_n,
	input logic slap_n,
	output word_t mdata,
	// Sound CPU side
	input sound_addr_t sba,
	input sound_sel_t srom_n,
	output byte_t sdata,
	// Controls
	input logic [10:0] ps2_key,
	input logic [31:0] joystick,
	output byte_t joy,
	output byte_t pb,
	output logic [2:0] coin_n
);

	load_addr_t load_addr;
	word_t load_word;
	byte_t load_byte;
	logic wr_rom0, wr_rom1, wr_rom2, wr_rom3, wr_slap;
	logic wr_srom0, wr_srom1, wr_srom2;
	logic [main_banks-1:0] wr_main;
	logic [sound_banks-1:0] wr_sound;
	word_t main_data [main_banks];
	byte_t sound_data [sound_banks];
	byte_t game_id;

	// ####################
	// Decode
	// ####################

	rom_load_decode u_decode (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr),
		.ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.load_addr(load_addr),
		.load_word(load_word),
		.load_byte(load_byte),
		.wr_rom0(wr_rom0),
		.wr_rom1(wr_rom1),
		.wr_rom2(wr_rom2),
		.wr_rom3(wr_rom3),
		.wr_slap(wr_slap),
		.wr_srom0(wr_srom0),
		.wr_srom1(wr_srom1),
		.wr_srom2(wr_srom2),
		.game_id(game_id)
	);

	// Bank order matches select priority
	assign wr_main = {wr_slap, wr_rom3, wr_rom2, wr_rom1, wr_rom0};
	assign wr_sound = {wr_srom2, wr_srom1, wr_srom0};

	// ####################
	// Banks
	// ####################

	// rom1 and rom2 are the 32K word banks
	for (genvar i = 0; i < main_banks; i++) begin : g_main
		rom_bank #(
			.addr_bits((i == 1 || i == 2) ? rom_bits_long : rom_bits_short),
			.payload_t(word_t)
		) u_bank (
			.clk_sys(clk_sys),
			.wr(wr_main[i]),
			.load_addr(load_addr),
			.wr_data(load_word),
			.rd_addr(madec),
			.rd_data(main_data[i])
		);
	end

	// Sound banks, 16K bytes each
	for (genvar i = 0; i < sound_banks; i++) begin : g_sound
		rom_bank #(
			.addr_bits(sound_addr_bits),
			.payload_t(byte_t)
		) u_bank (
			.clk_sys(clk_sys),
			.wr(wr_sound[i]),
			.load_addr(load_addr),
			.wr_data(load_byte),
			.rd_addr(main_addr_t'(sba)),
			.rd_data(sound_data[i])
		);
	end

	// ####################
	// Read select
	// ####################

	cart_read_select #(.payload_t(word_t), .n_banks(main_banks)) u_main_sel (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.sel_n({slap_n, rom_n}),
		.bank_data(main_data),
		.rd_data(mdata)
	);

	cart_read_select #(.payload_t(byte_t), .n_banks(sound_banks)) u_sound_sel (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.sel_n(srom_n),
		.bank_data(sound_data),
		.rd_data(sdata)
	);

	// Player inputs
	control_map u_controls (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.ps2_key(ps2_key),
		.joystick(joystick),
		.game_id(game_id),
		.joy(joy),
		.pb(pb),
		.coin_n(coin_n)
	);

endmodule

// ==== sources.f ====
hdl/sys1_cart_pkg.sv
hdl/rom_load_decode.sv
hdl/rom_bank.sv
hdl/cart_read_select.sv
hdl/control_map.sv
hdl/sys1_cart_top.sv
verif/tb_sys1_cart.sv

// ==== verif/tb_sys1_cart.sv ====
// Directed testbench for the System-1 cartridge top covering ROM download, bank reads and controls
`timescale 1ns/1ps

module tb_sys1_cart
	import sys1_cart_pkg::*;
();

	// Entries loaded per bank
	localparam int n_words = 6;
	localparam int n_bytes = 6;
	// Word pairs, sound bytes, reset word, two ignored pairs, three game ids
	localparam int total_bytes = 2 * n_words * main_banks + n_bytes * sound_banks + 2 + 4 + 3;
	localparam int timeout_ns = total_bytes * 8 * 4 + 10000;

	logic clk_sys;
	logic arst_n;
	logic ioctl_download;
	logic ioctl_wr;
	byte_t ioctl_index;
	load_addr_t ioctl_addr;
	byte_t ioctl_dout;
	main_addr_t madec;
	main_sel_t rom_n;
	logic slap_n;
	word_t mdata;
	sound_addr_t sba;
	sound_sel_t srom_n;
	byte_t sdata;
	logic [10:0] ps2_key;
	logic [31:0] joystick;
	byte_t joy;
	byte_t pb;
	logic [2:0] coin_n;

	integer seed;
	int errors;
	int checks;
	logic key_toggle;
	// Reference contents filled as bytes are sent
	word_t exp_main [main_banks][n_words];
	byte_t exp_sound [sound_banks][n_bytes];

	sys1_cart_top dut0 (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr),
		.ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.madec(madec),
		.rom_n(rom_n),
		.slap_n(slap_n),
		.mdata(mdata),
		.sba(sba),
		.srom_n(srom_n),
		.sdata(sdata),
		.ps2_key(ps2_key),
		.joystick(joystick),
		.joy(joy),
		.pb(pb),
		.coin_n(coin_n)
	);

	// 8 ns clock
	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Watchdog sized from the stream length
	initial begin
		#(timeout_ns);
		$display("Timeout: the tests did not finish in %0d ns", timeout_ns);
		$display("Errors found");
		$finish;
	end

	// ####################
	// Reference model
	// ####################

	// Region base from the tag over its address field
	function automatic load_addr_t main_base(input int b);
		case (b)
			0: return {tag_rom0, 15'h0};
			1: return {tag_rom1, 16'h0};
			2: return {tag_rom2, 16'h0};
			3: return {tag_rom3, 15'h0};
			default: return {tag_slap, 15'h0};
		endcase
	endfunction

	function automatic load_addr_t sound_base(input int b);
		case (b)
			0: return {tag_srom0, 14'h0};
			1: return {tag_srom1, 14'h0};
			default: return {tag_srom2, 14'h0};
		endcase
	endfunction

	// Spread addresses that stay inside the 16K entry banks
	function automatic main_addr_t word_addr(input int i);
		return main_addr_t'(i * 2053 + 17);
	endfunction

	function automatic sound_addr_t byte_addr(input int i);
		return sound_addr_t'(i * 1543 + 3);
	endfunction

	// Lowest selected bank wins or zero when none
	function automatic word_t main_expect(input logic [4:0] sel, input int i);
		for (int b = 0; b < main_banks; b++) begin
			if (!sel[b])
				return exp_main[b][i];
		end
		return '0;
	endfunction

	function automatic byte_t sound_expect(input sound_sel_t sel, input int i);
		for (int b = 0; b < sound_banks; b++) begin
			if (!sel[b])
				return exp_sound[b][i];
		end
		return '0;
	endfunction

	// Directions up, down, left and right shifted up one for Indy
	function automatic byte_t expected_joy(input byte_t game, input logic [3:0] dir);
		if (game == game_indy)
			return byte_t'({dir, 1'b0});
		return byte_t'(dir);
	endfunction

	// Active low with unused bits held high
	function automatic byte_t expected_pb(input byte_t game, input logic jump, input logic whip);
		byte_t v;
		v = '1;
		v[0] = ~whip;
		if (game == game_peter)
			v[2] = ~jump;
		else
			v[1] = ~jump;
		return v;
	endfunction

	function automatic byte_t expected_coin(input logic l, input logic r, input logic aux);
		return byte_t'({~aux, ~r, ~l});
	endfunction

	// ####################
	// Checks
	// ####################

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Joy, pb and coin_n all compared as bytes
	task automatic check_bus(input string name, input byte_t exp, input byte_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// ####################
	// Stimulus
	// ####################

	// Returns 1 ns after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic send_byte(input byte_t index, input load_addr_t addr, input byte_t data,
		input logic download);
		ioctl_index = index;
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_download = download;
		ioctl_wr = 1'b1;
		wait_cycles(1);
		ioctl_wr = 1'b0;
		ioctl_download = 1'b0;
	endtask

	// Selects as {slap_n, rom_n} with data one cycle later
	task automatic read_main(input main_addr_t addr, input logic [4:0] sel, output word_t data);
		madec = addr;
		{slap_n, rom_n} = sel;
		wait_cycles(1);
		data = mdata;
	endtask

	task automatic read_sound(input sound_addr_t addr, input sound_sel_t sel, output byte_t data);
		sba = addr;
		srom_n = sel;
		wait_cycles(1);
		data = sdata;
	endtask

	// One key event and two cycles to settle
	task automatic press_key(input logic [8:0] code, input logic down);
		key_toggle = ~key_toggle;
		ps2_key = {key_toggle, down, code};
		wait_cycles(2);
	endtask

	// ####################
	// Tests
	// ####################

	task automatic reset_state();
		byte_t hi;
		byte_t lo;
		check_bus("reset joy", 8'h00, joy);
		check_bus("reset pb", expected_pb(game_default, 1'b0, 1'b0), pb);
		check_bus("reset coin_n", expected_coin(1'b0, 1'b0, 1'b0), byte_t'(coin_n));
		hi = byte_t'($random(seed));
		lo = byte_t'($random(seed));
		send_byte(rom_index, main_base(0), hi, 1'b1);
		send_byte(rom_index, main_base(0) | 25'h1, lo, 1'b1);
		// Every select low across a second reset
		madec = '0;
		rom_n = '0;
		slap_n = 1'b0;
		sba = '0;
		srom_n = '0;
		arst_n = 1'b0;
		wait_cycles(2);
		arst_n = 1'b1;
		check_word("reset mdata", 16'h0000, mdata);
		check_byte("reset sdata", 8'h00, sdata);
		srom_n = '1;
		wait_cycles(1);
		check_word("first rom0 read", {hi, lo}, mdata);
		check_byte("no sound select", 8'h00, sdata);
		rom_n = '1;
		slap_n = 1'b1;
	endtask

	task automatic word_regions();
		byte_t hi;
		byte_t lo;
		word_t data;
		load_addr_t addr;
		for (int b = 0; b < main_banks; b++) begin
			for (int i = 0; i < n_words; i++) begin
				hi = byte_t'($random(seed));
				lo = byte_t'($random(seed));
				// Even byte is the high half
				exp_main[b][i] = {hi, lo};
				addr = main_base(b) | load_addr_t'({word_addr(i), 1'b0});
				send_byte(rom_index, addr, hi, 1'b1);
				send_byte(rom_index, addr | 25'h1, lo, 1'b1);
			end
		end
		for (int i = 0; i < n_words; i++) begin
			for (int b = 0; b < main_banks; b++) begin
				read_main(word_addr(i), ~(5'b00001 << b), data);
				check_word($sformatf("bank %0d word %0d", b, i), exp_main[b][i], data);
			end
		end
		// Every select pattern on one word
		for (int p = 0; p < 32; p++) begin
			read_main(word_addr(2), 5'(p), data);
			check_word($sformatf("main select %b", 5'(p)), main_expect(5'(p), 2), data);
		end
		rom_n = '1;
		slap_n = 1'b1;
	endtask

	task automatic sound_regions();
		byte_t data;
		for (int b = 0; b < sound_banks; b++) begin
			for (int i = 0; i < n_bytes; i++) begin
				exp_sound[b][i] = byte_t'($random(seed));
				send_byte(rom_index, sound_base(b) | load_addr_t'(byte_addr(i)),
					exp_sound[b][i], 1'b1);
			end
		end
		for (int i = 0; i < n_bytes; i++) begin
			for (int b = 0; b < sound_banks; b++) begin
				read_sound(byte_addr(i), ~(3'b001 << b), data);
				check_byte($sformatf("srom%0d byte %0d", b, i), exp_sound[b][i], data);
			end
		end
		// All patterns where 3'b111 reads zero
		for (int p = 0; p < 8; p++) begin
			read_sound(byte_addr(4), 3'(p), data);
			check_byte($sformatf("sound select %b", 3'(p)), sound_expect(3'(p), 4), data);
		end
		srom_n = '1;
	endtask

	task automatic ignored_writes();
		word_t data;
		load_addr_t addr;
		byte_t hi;
		byte_t lo;
		addr = main_base(0) | load_addr_t'({word_addr(0), 1'b0});
		hi = exp_main[0][0][15:8];
		lo = exp_main[0][0][7:0];
		// Index 1 during a download also reloads game_id
		send_byte(id_index, addr, ~hi, 1'b1);
		send_byte(id_index, addr | 25'h1, ~lo, 1'b1);
		read_main(word_addr(0), 5'b11110, data);
		check_word("index 1 write", exp_main[0][0], data);
		// ROM index without the download level
		send_byte(rom_index, addr, ~hi, 1'b0);
		send_byte(rom_index, addr | 25'h1, ~lo, 1'b0);
		read_main(word_addr(0), 5'b11110, data);
		check_word("download low write", exp_main[0][0], data);
		rom_n = '1;
	endtask

	task automatic layout_case(input byte_t game);
		send_byte(id_index, '0, game, 1'b0);
		// Up and whip from keys and jump from the joystick
		press_key(key_up, 1'b1);
		press_key(key_whip, 1'b1);
		joystick[4] = 1'b1;
		wait_cycles(2);
		check_bus($sformatf("game %0d joy up", game), expected_joy(game, 4'b1000), joy);
		check_bus($sformatf("game %0d pb both", game), expected_pb(game, 1'b1, 1'b1), pb);
		// Up and right from the joystick with whip released
		joystick[3] = 1'b1;
		joystick[0] = 1'b1;
		press_key(key_up, 1'b0);
		press_key(key_whip, 1'b0);
		check_bus($sformatf("game %0d joy up right", game), expected_joy(game, 4'b1001), joy);
		check_bus($sformatf("game %0d pb jump", game), expected_pb(game, 1'b1, 1'b0), pb);
		joystick = '0;
		wait_cycles(2);
		check_bus($sformatf("game %0d joy idle", game), expected_joy(game, 4'b0000), joy);
		check_bus($sformatf("game %0d pb idle", game), expected_pb(game, 1'b0, 1'b0), pb);
	endtask

	task automatic game_layouts();
		layout_case(game_indy);
		layout_case(game_peter);
		layout_case(game_marble);
	endtask

	task automatic coin_events();
		press_key(key_coin_l, 1'b1);
		check_bus("coin left", expected_coin(1'b1, 1'b0, 1'b0), byte_t'(coin_n));
		press_key(key_coin_l, 1'b0);
		check_bus("coin left up", expected_coin(1'b0, 1'b0, 1'b0), byte_t'(coin_n));
		press_key(key_coin_r, 1'b1);
		check_bus("coin right", expected_coin(1'b0, 1'b1, 1'b0), byte_t'(coin_n));
		press_key(key_coin_r, 1'b0);
		press_key(key_coin_aux, 1'b1);
		check_bus("coin aux", expected_coin(1'b0, 1'b0, 1'b1), byte_t'(coin_n));
		press_key(key_coin_aux, 1'b0);
		check_bus("coin aux up", expected_coin(1'b0, 1'b0, 1'b0), byte_t'(coin_n));
		// Host button shares the left coin
		joystick[8] = 1'b1;
		wait_cycles(2);
		check_bus("coin joystick", expected_coin(1'b1, 1'b0, 1'b0), byte_t'(coin_n));
		joystick[8] = 1'b0;
		wait_cycles(2);
		check_bus("coin idle", expected_coin(1'b0, 1'b0, 1'b0), byte_t'(coin_n));
	endtask

	// ####################
	// Sequence
	// ####################

	initial begin
		seed = 32'h38c1_43c3;
		errors = 0;
		checks = 0;
		key_toggle = 1'b0;
		arst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		madec = '0;
		rom_n = '1;
		slap_n = 1'b1;
		sba = '0;
		srom_n = '1;
		ps2_key = '0;
		joystick = '0;
		repeat (10) @(posedge clk_sys);
		#1;
		arst_n = 1'b1;
		reset_state();
		word_regions();
		sound_regions();
		ignored_writes();
		game_layouts();
		coin_events();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
